// File: verilog/ft_usb_cfg.svh
// Timing counts, key symbols, symbol counts and widths of the FT245R packet bridge
`ifndef FT_USB_CFG_SVH
`define FT_USB_CFG_SVH

// Bus and word widths
`define FT_BYTE_W 8
`define FT_WORD_W 16

// Packet RAM geometry
`define FT_RAM_WORDS 2048
`define FT_RAM_AW 11

// Read cycle marks in clk counts
`define FT_RD_SAMPLE_T 9
`define FT_RD_STROBE_ON_T 2
`define FT_RD_STROBE_OFF_T 12
`define FT_RD_END_T 25

// Write cycle marks in clk counts
`define FT_WR_STROBE_ON_T 5
`define FT_WR_STROBE_OFF_T 15
`define FT_WR_END_T 25

// Framing symbols
`define FT_HEADER_SYM 8'h55
`define FT_HEADER_CNT 12
`define FT_TRAILER_SYM 8'hAA
`define FT_TRAILER_CNT 8
`define FT_ERROR_SYM 8'hEE

// Length word counts length, service, data and trailer
`define FT_MIN_LENGTH 12
`define FT_TX_CREDITS 1

`endif

// File: verilog/ft_usb_pkg.sv
// Bridge package with received byte, RAM write, packet info, RAM word and transmit byte types
`include "ft_usb_cfg.svh"

package ft_usb_pkg;

	// Byte from the read port, valid is a single-cycle pulse
	typedef struct packed {
		logic valid;
		logic [`FT_BYTE_W-1:0] data;
	} rx_byte_t;

	// Port A write request into the packet RAM
	typedef struct packed {
		logic we;
		logic [`FT_RAM_AW-1:0] addr;
		logic [`FT_WORD_W-1:0] data;
	} ram_wr_t;

	// Result of a finished packet
	// Error set on short length or overrun
	typedef struct packed {
		logic [`FT_WORD_W-1:0] length;
		logic [`FT_WORD_W-1:0] service;
		logic error;
	} packet_info_t;

	// High and low byte of one word
	typedef struct packed {
		logic [`FT_BYTE_W-1:0] hi;
		logic [`FT_BYTE_W-1:0] lo;
	} byte_pair_t;

	// Word seen whole or as two bytes
	// Bytes travel low first on the wire
	typedef union packed {
		logic [`FT_WORD_W-1:0] word;
		byte_pair_t bytes;
	} ram_word_u;

	// Byte offered by the framer to the write port
	typedef struct packed {
		logic valid;
		logic [`FT_BYTE_W-1:0] data;
	} tx_byte_t;

endpackage

// File: verilog/ft_read_port.sv
// FT245R read port with receive-ready synchronizer and timed read cycle
`timescale 1ns/1ns
`include "ft_usb_cfg.svh"

module ft_read_port
	import ft_usb_pkg::*;
(
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  ft_rxf_n,
	input  logic [`FT_BYTE_W-1:0] ft_data_in,
	output logic                  ft_rd_n,
	output rx_byte_t              rx,
	output logic                  rd_busy
);

	localparam int RD_CNT_W = $clog2(`FT_RD_END_T + 1);
	localparam logic [RD_CNT_W-1:0] RD_ON = `FT_RD_STROBE_ON_T;
	localparam logic [RD_CNT_W-1:0] RD_OFF = `FT_RD_STROBE_OFF_T;
	localparam logic [RD_CNT_W-1:0] RD_SAMPLE = `FT_RD_SAMPLE_T;
	localparam logic [RD_CNT_W-1:0] RD_END = `FT_RD_END_T;

	// Two sync flops, third one for edge detect
	logic rxf_meta;
	logic rxf_sync;
	logic rxf_last;
	logic rxf_fall;
	logic [RD_CNT_W-1:0] rd_cnt;
	logic rd_strobe;
	logic rx_valid_q;
	logic [`FT_BYTE_W-1:0] rx_data_q;

	// Data waiting in FIFO
	assign rxf_fall = rxf_last && !rxf_sync;

	//======================================================================
	// Read cycle timing
	//======================================================================
	always_ff @(posedge clk) begin
		if (reset) begin
			rxf_meta <= 1'b1;
			rxf_sync <= 1'b1;
			rxf_last <= 1'b1;
			rd_busy <= 1'b0;
			rd_cnt <= '0;
			rd_strobe <= 1'b0;
			rx_valid_q <= 1'b0;
		end else begin
			rxf_meta <= ft_rxf_n;
			rxf_sync <= rxf_meta;
			rxf_last <= rxf_sync;
			// Valid one cycle behind the sample point
			rx_valid_q <= rd_busy && (rd_cnt == RD_SAMPLE);
			if (!rd_busy) begin
				// Edges inside a cycle never reach here
				if (rxf_fall) begin
					rd_busy <= 1'b1;
					rd_cnt <= '0;
				end
			end else begin
				rd_cnt <= rd_cnt + 1'b1;
				if (rd_cnt == RD_ON)
					rd_strobe <= 1'b1;
				if (rd_cnt == RD_OFF)
					rd_strobe <= 1'b0;
				if (rd_cnt == RD_END) begin
					rd_busy <= 1'b0;
					rd_cnt <= '0;
				end
			end
		end
	end

	// Bus is stable well inside the strobe window
	always_ff @(posedge clk) begin
		if (rd_busy && (rd_cnt == RD_SAMPLE))
			rx_data_q <= ft_data_in;
	end

	assign ft_rd_n = !rd_strobe;
	assign rx.valid = rx_valid_q;
	assign rx.data = rx_data_q;

	// Strobe confined to an active cycle
	a_rd_in_cycle: assert property (@(posedge clk) disable iff (reset)
		!ft_rd_n |-> rd_busy);

endmodule

// File: verilog/packet_receiver.sv
// Packet receiver with header and trailer detect, field capture, length checks and RAM writes
`timescale 1ns/1ns
`include "ft_usb_cfg.svh"

module packet_receiver
	import ft_usb_pkg::*;
(
	input  logic         clk,
	input  logic         reset,
	input  rx_byte_t     rx,
	output ram_wr_t      ram_wr,
	output logic         done,
	output packet_info_t info,
	output logic         header_seen,
	output logic         trailer_seen,
	output logic         packet_active
);

	localparam int H_CNT_W = $clog2(`FT_HEADER_CNT + 1);
	localparam int T_CNT_W = $clog2(`FT_TRAILER_CNT + 1);
	localparam logic [H_CNT_W-1:0] H_LAST = `FT_HEADER_CNT - 1;
	localparam logic [T_CNT_W-1:0] T_LAST = `FT_TRAILER_CNT - 1;
	localparam logic [`FT_WORD_W-1:0] DATA_START = 4;
	localparam logic [`FT_WORD_W-1:0] MIN_LEN = `FT_MIN_LENGTH;

	logic [H_CNT_W-1:0] h_cnt;
	logic [T_CNT_W-1:0] t_cnt;
	logic header_lock;
	logic trailer_lock;
	logic err_pulse;
	logic [`FT_WORD_W-1:0] byte_idx;
	logic [`FT_WORD_W-1:0] data_idx;
	logic in_packet;
	logic len_short;
	logic len_over;
	logic bad_byte;
	packet_info_t info_q;
	ram_word_u data_word;
	logic wr_en_q;
	// Full word index, wider than the RAM address
	logic [`FT_WORD_W-2:0] wr_word_q;

	assign in_packet = rx.valid && packet_active;
	assign data_idx = byte_idx - DATA_START;
	// Length known once index 2 arrives
	assign len_short = (byte_idx == 2) && (info_q.length < MIN_LEN);
	assign len_over = (byte_idx >= 2) && (byte_idx >= info_q.length);
	assign bad_byte = in_packet && (len_short || len_over);

	//======================================================================
	// Key symbol counters
	//======================================================================
	always_ff @(posedge clk) begin
		if (reset) begin
			h_cnt <= '0;
			t_cnt <= '0;
			header_lock <= 1'b0;
			trailer_lock <= 1'b0;
		end else begin
			header_lock <= 1'b0;
			trailer_lock <= 1'b0;
			// Header searched only between packets
			if (rx.valid && !packet_active) begin
				if (rx.data != `FT_HEADER_SYM)
					h_cnt <= '0;
				else if (h_cnt == H_LAST) begin
					h_cnt <= '0;
					header_lock <= 1'b1;
				end else
					h_cnt <= h_cnt + 1'b1;
			end
			if (header_lock)
				t_cnt <= '0;
			else if (in_packet) begin
				if (rx.data != `FT_TRAILER_SYM)
					t_cnt <= '0;
				else if (t_cnt == T_LAST) begin
					t_cnt <= '0;
					trailer_lock <= 1'b1;
				end else
					t_cnt <= t_cnt + 1'b1;
			end
		end
	end

	//======================================================================
	// Byte index, fields and errors
	//======================================================================
	always_ff @(posedge clk) begin
		if (reset) begin
			packet_active <= 1'b0;
			byte_idx <= '0;
			err_pulse <= 1'b0;
			done <= 1'b0;
			info_q <= '0;
		end else begin
			err_pulse <= 1'b0;
			done <= trailer_lock || err_pulse;
			if (header_lock) begin
				packet_active <= 1'b1;
				byte_idx <= '0;
				info_q <= '0;
			end else if (in_packet) begin
				byte_idx <= byte_idx + 1'b1;
				// Little-endian length, then service
				case (byte_idx)
					16'd0: info_q.length[7:0] <= rx.data;
					16'd1: info_q.length[15:8] <= rx.data;
					16'd2: info_q.service[7:0] <= rx.data;
					16'd3: info_q.service[15:8] <= rx.data;
					default: ;
				endcase
				if (bad_byte) begin
					info_q.error <= 1'b1;
					err_pulse <= 1'b1;
					packet_active <= 1'b0;
				end
			end
			if (trailer_lock)
				packet_active <= 1'b0;
		end
	end

	// Low byte first, word complete on the odd index
	always_ff @(posedge clk) begin
		if (in_packet && (byte_idx >= DATA_START)) begin
			if (data_idx[0])
				data_word.bytes.hi <= rx.data;
			else
				data_word.bytes.lo <= rx.data;
		end
	end

	// Write one cycle after the high byte
	always_ff @(posedge clk) begin
		if (reset)
			wr_en_q <= 1'b0;
		else
			wr_en_q <= in_packet && (byte_idx >= DATA_START) && data_idx[0];
		wr_word_q <= data_idx[`FT_WORD_W-1:1];
	end

	assign ram_wr.we = wr_en_q;
	assign ram_wr.addr = wr_word_q[`FT_RAM_AW-1:0];
	assign ram_wr.data = data_word.word;
	assign info = info_q;
	assign header_seen = header_lock;
	assign trailer_seen = trailer_lock;

	// Packet length must fit the RAM
	a_ram_range: assert property (@(posedge clk) disable iff (reset)
		ram_wr.we |-> (wr_word_q < `FT_RAM_WORDS));

endmodule

// File: verilog/packet_ram.sv
// Packet data RAM with one write port and one registered read port
`timescale 1ns/1ns
`include "ft_usb_cfg.svh"

module packet_ram
	import ft_usb_pkg::*;
(
	input  logic                  clk,
	input  ram_wr_t               ram_wr,
	input  logic [`FT_RAM_AW-1:0] rd_addr,
	output ram_word_u             rd_word
);

	// Data words of the current packet
	logic [`FT_WORD_W-1:0] mem [`FT_RAM_WORDS];

	//======================================================================
	// Port A, receiver writes
	//======================================================================
	always_ff @(posedge clk) begin
		if (ram_wr.we)
			mem[ram_wr.addr] <= ram_wr.data;
	end

	//======================================================================
	// Port B, framer reads
	//======================================================================
	// Data one cycle after the address
	always_ff @(posedge clk) begin
		rd_word.word <= mem[rd_addr];
	end

endmodule

// File: verilog/reply_framer.sv
// Reply framer with byte sequencer, RAM prefetch and transmit credit counter
`timescale 1ns/1ns
`include "ft_usb_cfg.svh"

module reply_framer
	import ft_usb_pkg::*;
(
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  done,
	input  packet_info_t          info,
	output logic [`FT_RAM_AW-1:0] rd_addr,
	input  ram_word_u             rd_word,
	output tx_byte_t              tx,
	input  logic                  credit_return,
	output logic                  busy
);

	localparam int IDX_W = `FT_WORD_W + 1;
	localparam int CR_W = $clog2(`FT_TX_CREDITS + 1);
	localparam logic [CR_W-1:0] CR_FULL = `FT_TX_CREDITS;
	localparam logic [IDX_W-1:0] LEN_IDX = `FT_HEADER_CNT;
	localparam logic [IDX_W-1:0] DATA_IDX = `FT_HEADER_CNT + 4;
	localparam logic [IDX_W-1:0] TRL_N = `FT_TRAILER_CNT;
	localparam logic [`FT_WORD_W-1:0] MIN_LEN = `FT_MIN_LENGTH;

	packet_info_t info_q;
	logic [`FT_WORD_W-1:0] data_n;
	logic [IDX_W-1:0] out_idx;
	logic [IDX_W-1:0] data_end;
	logic [IDX_W-1:0] frame_end;
	logic [IDX_W-1:0] data_off;
	logic in_data;
	logic send;
	logic [CR_W-1:0] credit_cnt;
	logic [`FT_BYTE_W-1:0] next_byte;
	logic [`FT_RAM_AW-1:0] rd_addr_q;
	tx_byte_t tx_q;

	// No data bytes for short lengths
	assign data_n = (info_q.length > MIN_LEN) ? (info_q.length - MIN_LEN) : '0;
	assign data_end = DATA_IDX + {1'b0, data_n};
	assign frame_end = data_end + TRL_N;
	assign data_off = out_idx - DATA_IDX;
	assign in_data = (out_idx >= DATA_IDX) && (out_idx < data_end);
	assign send = busy && (credit_cnt != '0) && (out_idx < frame_end);

	//======================================================================
	// Byte select
	//======================================================================
	always_comb begin
		if (out_idx < LEN_IDX)
			next_byte = `FT_HEADER_SYM;
		else if (out_idx == LEN_IDX)
			next_byte = info_q.length[7:0];
		else if (out_idx == LEN_IDX + 1'b1)
			next_byte = info_q.length[15:8];
		else if (out_idx == LEN_IDX + 2'd2)
			next_byte = info_q.error ? `FT_ERROR_SYM : info_q.service[7:0];
		else if (out_idx == LEN_IDX + 2'd3)
			next_byte = info_q.error ? `FT_ERROR_SYM : info_q.service[15:8];
		else if (in_data)
			// Even offset is the low byte
			next_byte = data_off[0] ? rd_word.bytes.hi : rd_word.bytes.lo;
		else
			next_byte = `FT_TRAILER_SYM;
	end

	//======================================================================
	// Sequencer and credits
	//======================================================================
	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			out_idx <= '0;
			rd_addr_q <= '0;
			credit_cnt <= CR_FULL;
			tx_q <= '0;
		end else begin
			tx_q.valid <= send;
			if (send)
				tx_q.data <= next_byte;
			case ({send, credit_return})
				2'b10: credit_cnt <= credit_cnt - 1'b1;
				2'b01: credit_cnt <= credit_cnt + 1'b1;
				default: ;
			endcase
			if (!busy) begin
				// A done while busy is dropped
				if (done) begin
					busy <= 1'b1;
					out_idx <= '0;
					rd_addr_q <= '0;
				end
			end else begin
				if (send) begin
					out_idx <= out_idx + 1'b1;
					// Prefetch next word after its high byte
					if (in_data && data_off[0])
						rd_addr_q <= rd_addr_q + 1'b1;
				end
				// Finished once the last byte is written out
				if ((out_idx == frame_end) && (credit_cnt == CR_FULL))
					busy <= 1'b0;
			end
		end
	end

	// Snapshot, the receiver may start the next packet
	always_ff @(posedge clk) begin
		if (!busy && done)
			info_q <= info;
	end

	assign rd_addr = rd_addr_q;
	assign tx = tx_q;

	a_credit_max: assert property (@(posedge clk) disable iff (reset)
		credit_cnt <= CR_FULL);

endmodule

// File: verilog/ft_write_port.sv
// FT245R write port with holding register, transmit-empty synchronizer and timed write cycle
`timescale 1ns/1ns
`include "ft_usb_cfg.svh"

module ft_write_port
	import ft_usb_pkg::*;
(
	input  logic                  clk,
	input  logic                  reset,
	input  tx_byte_t              tx,
	input  logic                  ft_txe_n,
	output logic                  ft_wr,
	output logic [`FT_BYTE_W-1:0] ft_data_out,
	output logic                  credit_return,
	output logic                  wr_busy
);

	localparam int WR_CNT_W = $clog2(`FT_WR_END_T + 1);
	localparam logic [WR_CNT_W-1:0] WR_ON = `FT_WR_STROBE_ON_T;
	localparam logic [WR_CNT_W-1:0] WR_OFF = `FT_WR_STROBE_OFF_T;
	localparam logic [WR_CNT_W-1:0] WR_END = `FT_WR_END_T;

	logic txe_meta;
	logic txe_sync;
	logic hold_valid;
	logic [`FT_BYTE_W-1:0] hold_data;
	logic [WR_CNT_W-1:0] wr_cnt;
	logic wr_start;

	// Byte held and FIFO has room
	assign wr_start = hold_valid && !wr_busy && !txe_sync;

	//======================================================================
	// Write cycle timing
	//======================================================================
	always_ff @(posedge clk) begin
		if (reset) begin
			txe_meta <= 1'b1;
			txe_sync <= 1'b1;
			hold_valid <= 1'b0;
			wr_busy <= 1'b0;
			wr_cnt <= '0;
			ft_wr <= 1'b0;
			credit_return <= 1'b0;
		end else begin
			txe_meta <= ft_txe_n;
			txe_sync <= txe_meta;
			credit_return <= 1'b0;
			if (tx.valid)
				hold_valid <= 1'b1;
			if (wr_start) begin
				wr_busy <= 1'b1;
				wr_cnt <= '0;
			end else if (wr_busy) begin
				wr_cnt <= wr_cnt + 1'b1;
				if (wr_cnt == WR_ON)
					ft_wr <= 1'b1;
				if (wr_cnt == WR_OFF)
					ft_wr <= 1'b0;
				// Frees the register and hands the credit back
				if (wr_cnt == WR_END) begin
					wr_busy <= 1'b0;
					wr_cnt <= '0;
					hold_valid <= 1'b0;
					credit_return <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (tx.valid)
			hold_data <= tx.data;
	end

	// Bus driven only for the cycle
	assign ft_data_out = wr_busy ? hold_data : '0;

	// Framer must wait for the credit
	a_no_overrun: assert property (@(posedge clk) disable iff (reset)
		tx.valid |-> !hold_valid);

endmodule

// File: verilog/ft_usb_bridge.sv
// Top level of the FT245R packet bridge with read port, receiver, RAM, framer and write port
`timescale 1ns/1ns
`include "ft_usb_cfg.svh"

module ft_usb_bridge
	import ft_usb_pkg::*;
(
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  ft_rxf_n,
	input  logic [`FT_BYTE_W-1:0] ft_data_in,
	output logic                  ft_rd_n,
	input  logic                  ft_txe_n,
	output logic                  ft_wr,
	output logic [`FT_BYTE_W-1:0] ft_data_out,
	output logic                  usb_active,
	output logic                  packet_active,
	output logic                  header_seen,
	output logic                  trailer_seen
);

	rx_byte_t rx;
	ram_wr_t ram_wr;
	logic done;
	packet_info_t info;
	logic [`FT_RAM_AW-1:0] rd_addr;
	ram_word_u rd_word;
	tx_byte_t tx;
	logic credit_return;
	logic rd_busy;
	logic wr_busy;

	//======================================================================
	// Receive side
	//======================================================================
	ft_read_port i_ft_read_port (
		.clk         (clk),
		.reset       (reset),
		.ft_rxf_n    (ft_rxf_n),
		.ft_data_in  (ft_data_in),
		.ft_rd_n     (ft_rd_n),
		.rx          (rx),
		.rd_busy     (rd_busy)
	);

	packet_receiver i_packet_receiver (
		.clk           (clk),
		.reset         (reset),
		.rx            (rx),
		.ram_wr        (ram_wr),
		.done          (done),
		.info          (info),
		.header_seen   (header_seen),
		.trailer_seen  (trailer_seen),
		.packet_active (packet_active)
	);

	packet_ram i_packet_ram (
		.clk     (clk),
		.ram_wr  (ram_wr),
		.rd_addr (rd_addr),
		.rd_word (rd_word)
	);

	//======================================================================
	// Reply side
	//======================================================================
	// Busy left open, it only marks the reply end
	reply_framer i_reply_framer (
		.clk           (clk),
		.reset         (reset),
		.done          (done),
		.info          (info),
		.rd_addr       (rd_addr),
		.rd_word       (rd_word),
		.tx            (tx),
		.credit_return (credit_return),
		.busy          ()
	);

	ft_write_port i_ft_write_port (
		.clk           (clk),
		.reset         (reset),
		.tx            (tx),
		.ft_txe_n      (ft_txe_n),
		.ft_wr         (ft_wr),
		.ft_data_out   (ft_data_out),
		.credit_return (credit_return),
		.wr_busy       (wr_busy)
	);

	// Any bus cycle in progress
	assign usb_active = rd_busy || wr_busy;

endmodule

// File: tests/ft_usb_bridge_tb.sv
// Testbench for the FT245R packet bridge with FIFO model, reply sink, reference function and compare
`timescale 1ns/1ns
`include "ft_usb_cfg.svh"

module ft_usb_bridge_tb;

	typedef logic [`FT_BYTE_W-1:0] byte_q_t[$];

	logic clk;
	logic reset;
	logic ft_rxf_n;
	logic [`FT_BYTE_W-1:0] ft_data_in;
	logic ft_rd_n;
	logic ft_txe_n;
	logic ft_wr;
	logic [`FT_BYTE_W-1:0] ft_data_out;
	logic usb_active;
	logic packet_active;
	logic header_seen;
	logic trailer_seen;

	integer seed = 32'h9297_cd06;
	// Expected and collected reply bytes
	byte_q_t exp_q;
	byte_q_t got_q;
	byte_q_t data_q;
	logic [`FT_BYTE_W-1:0] exp_byte;
	logic [`FT_BYTE_W-1:0] got_byte;
	logic wr_last;
	int checked;
	// Header and trailer pulses, seen and expected
	int hdr_n;
	int trl_n;
	int hdr_exp;
	int trl_exp;

	ft_usb_bridge i_ft_usb_bridge (
		.clk           (clk),
		.reset         (reset),
		.ft_rxf_n      (ft_rxf_n),
		.ft_data_in    (ft_data_in),
		.ft_rd_n       (ft_rd_n),
		.ft_txe_n      (ft_txe_n),
		.ft_wr         (ft_wr),
		.ft_data_out   (ft_data_out),
		.usb_active    (usb_active),
		.packet_active (packet_active),
		.header_seen   (header_seen),
		.trailer_seen  (trailer_seen)
	);

	// 8 ns period
	always #4 clk = ~clk;

	//======================================================================
	// Reference reply and checks
	//======================================================================
	// Header, echoed length, service or error pair, data, trailer
	function automatic byte_q_t expected_reply(input logic [15:0] length,
		input logic [15:0] service, input byte_q_t data);
		byte_q_t reply;
		logic err;
		int n;
		// Short length or more bytes than the length announces
		err = (length < `FT_MIN_LENGTH) || ((`FT_MIN_LENGTH + data.size()) > length);
		n = (length > `FT_MIN_LENGTH) ? (length - `FT_MIN_LENGTH) : 0;
		repeat (`FT_HEADER_CNT) reply.push_back(`FT_HEADER_SYM);
		reply.push_back(length[7:0]);
		reply.push_back(length[15:8]);
		reply.push_back(err ? `FT_ERROR_SYM : service[7:0]);
		reply.push_back(err ? `FT_ERROR_SYM : service[15:8]);
		for (int i = 0; i < n; i++)
			reply.push_back((i < data.size()) ? data[i] : 8'h00);
		repeat (`FT_TRAILER_CNT) reply.push_back(`FT_TRAILER_SYM);
		return reply;
	endfunction

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("ERRORS FOUND");
		$fatal(1);
	endtask

	task automatic check_byte(input logic [`FT_BYTE_W-1:0] expected,
		input logic [`FT_BYTE_W-1:0] actual, input int index);
		if (actual !== expected)
			abort_run($sformatf("MISMATCH at %0t ns: reply byte %0d expected 0x%02h, got 0x%02h",
				$time, index, expected, actual));
	endtask

	task automatic check_flag(input logic expected, input logic actual, input string what);
		if (actual !== expected)
			abort_run($sformatf("MISMATCH at %0t ns: %s expected %b, got %b",
				$time, what, expected, actual));
	endtask

	task automatic check_count(input int expected, input int actual, input string what);
		if (actual != expected)
			abort_run($sformatf("MISMATCH at %0t ns: %s expected %0d, got %0d",
				$time, what, expected, actual));
	endtask

	//======================================================================
	// FIFO model, read side
	//======================================================================
	task automatic fifo_send_byte(input logic [`FT_BYTE_W-1:0] value);
		int wait_cnt;
		int gap;
		@(posedge clk);
		#1 ft_rxf_n = 1'b0;
		wait_cnt = 0;
		while (ft_rd_n) begin
			@(posedge clk);
			#1 wait_cnt++;
			if (wait_cnt > 40)
				abort_run("Timeout: read strobe never went low after the FIFO signalled data");
		end
		// Byte on the bus while the strobe is low
		ft_data_in = value;
		wait_cnt = 0;
		while (!ft_rd_n) begin
			@(posedge clk);
			#1 wait_cnt++;
			if (wait_cnt > 40)
				abort_run("Timeout: read strobe stuck low");
		end
		ft_rxf_n = 1'b1;
		ft_data_in = '0;
		gap = 30 + ($unsigned($random(seed)) % 31);
		repeat (gap) @(posedge clk);
	endtask

	// Random data with no trailer symbol
	task automatic fill_data(input int n);
		logic [`FT_BYTE_W-1:0] b;
		data_q = {};
		repeat (n) begin
			b = $random(seed);
			if (b == `FT_TRAILER_SYM)
				b = 8'h5A;
			data_q.push_back(b);
		end
	endtask

	// Optional noise, then header and fields, then data and trailer when full
	task automatic send_packet(input int noise_n, input logic [15:0] length,
		input logic [15:0] service, input byte_q_t data, input bit full);
		byte_q_t reply;
		logic [`FT_BYTE_W-1:0] noise;
		reply = expected_reply(length, service, data);
		foreach (reply[i])
			exp_q.push_back(reply[i]);
		hdr_exp++;
		if (full)
			trl_exp++;
		repeat (noise_n) begin
			noise = $random(seed);
			if (noise == `FT_HEADER_SYM)
				noise = 8'h00;
			fifo_send_byte(noise);
		end
		repeat (`FT_HEADER_CNT) fifo_send_byte(`FT_HEADER_SYM);
		@(negedge clk);
		check_flag(1'b1, packet_active, "packet_active after the header");
		fifo_send_byte(length[7:0]);
		fifo_send_byte(length[15:8]);
		fifo_send_byte(service[7:0]);
		fifo_send_byte(service[15:8]);
		if (full) begin
			foreach (data[i])
				fifo_send_byte(data[i]);
			repeat (`FT_TRAILER_CNT) fifo_send_byte(`FT_TRAILER_SYM);
		end
		// Trailer or length error closes the packet
		@(negedge clk);
		check_flag(1'b0, packet_active, "packet_active after the packet");
	endtask

	task automatic wait_reply(input string name);
		int wait_cnt;
		wait_cnt = 0;
		while (exp_q.size() != 0) begin
			@(negedge clk);
			wait_cnt++;
			if (wait_cnt > 20000)
				abort_run($sformatf("Timeout: reply to %s incomplete with %0d bytes missing",
					name, exp_q.size()));
		end
		wait_cnt = 0;
		while (usb_active) begin
			@(negedge clk);
			wait_cnt++;
			if (wait_cnt > 200)
				abort_run("Timeout: bus cycle still active after the reply ended");
		end
		// Room for a stray extra byte to show up
		repeat (64) @(posedge clk);
		check_count(hdr_exp, hdr_n, "header_seen pulses");
		check_count(trl_exp, trl_n, "trailer_seen pulses");
		$display("Reply to %s complete, %0d bytes checked", name, checked);
	endtask

	//======================================================================
	// Reply sink and compare
	//======================================================================
	// Transmit-empty holds
	initial begin : txe_holds
		int room_n;
		int hold_n;
		forever begin
			@(negedge clk);
			room_n = 5 + ($unsigned($random(seed)) % 36);
			hold_n = 1 + ($unsigned($random(seed)) % 15);
			repeat (room_n) @(posedge clk);
			#1 ft_txe_n = 1'b1;
			repeat (hold_n) @(posedge clk);
			#1 ft_txe_n = 1'b0;
		end
	end

	// Byte taken on the strobe's rising edge
	always @(negedge clk) begin
		if (ft_wr && !wr_last)
			got_q.push_back(ft_data_out);
		wr_last = ft_wr;
	end

	// Status pulses, and activity flag during either strobe
	always @(negedge clk) begin
		if (!reset) begin
			if (header_seen === 1'b1)
				hdr_n++;
			if (trailer_seen === 1'b1)
				trl_n++;
			if (!ft_rd_n || ft_wr)
				check_flag(1'b1, usb_active, "usb_active during a bus strobe");
		end
	end

	always @(posedge clk) begin
		if (got_q.size() != 0) begin
			got_byte = got_q.pop_front();
			if (exp_q.size() == 0)
				abort_run($sformatf("Reply byte 0x%02h arrived with no reply expected", got_byte));
			else begin
				exp_byte = exp_q.pop_front();
				check_byte(exp_byte, got_byte, checked);
				checked++;
			end
		end
	end

	//======================================================================
	// Stimulus
	//======================================================================
	initial begin
		clk = 1'b0;
		reset = 1'b1;
		ft_rxf_n = 1'b1;
		ft_data_in = '0;
		ft_txe_n = 1'b0;
		wr_last = 1'b0;
		checked = 0;
		hdr_n = 0;
		trl_n = 0;
		hdr_exp = 0;
		trl_exp = 0;
		repeat (10) @(posedge clk);
		#1 reset = 1'b0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		check_flag(1'b0, usb_active, "usb_active after reset");
		check_flag(1'b0, packet_active, "packet_active after reset");

		// Valid packet, 20 data bytes
		fill_data(20);
		send_packet(0, 16'd32, 16'hA5C3, data_q, 1'b1);
		wait_reply("20-byte packet");

		// Minimal packet, no data
		data_q = {};
		send_packet(0, 16'd12, 16'h0107, data_q, 1'b1);
		wait_reply("minimal packet");

		// Length 10 stops after the fields
		send_packet(0, 16'd10, 16'h3C4B, data_q, 1'b0);
		wait_reply("short-length packet");

		// Noise ahead of the header
		fill_data(8);
		send_packet(6, 16'd20, 16'h0902, data_q, 1'b1);
		wait_reply("packet after noise");

		// Three packets with no wait between them
		for (int p = 0; p < 3; p++) begin
			fill_data(16);
			send_packet(0, 16'd28, 16'h0200 + p, data_q, 1'b1);
		end
		wait_reply("back-to-back packets");

		$display("NO ERRORS");
		$finish;
	end

endmodule

// File: ft_usb_bridge.f
+incdir+verilog
verilog/ft_usb_pkg.sv
verilog/ft_read_port.sv
verilog/packet_receiver.sv
verilog/packet_ram.sv
verilog/reply_framer.sv
verilog/ft_write_port.sv
verilog/ft_usb_bridge.sv
tests/ft_usb_bridge_tb.sv
